/* vp8_recon_pkg.sv */
// VP8 reconstruction shared definitions
`default_nettype none

package vp8_recon_pkg;

    // ------------------------------------------------------------
    // Datapath widths
    // ------------------------------------------------------------
    localparam int blk_n   = 16;
    localparam int coef_w  = 16;
    localparam int pix_w   = 8;
    localparam int quant_w = 9;
    // First pass intermediate
    localparam int tmp_w   = 19;
    // Second pass sums, two bits of headroom over tmp_w
    localparam int sum_w   = tmp_w + 2;
    // Signed coefficient times zero-extended factor
    localparam int prod_w  = coef_w + quant_w + 1;

    // ------------------------------------------------------------
    // Transform constants, 16-bit fixed point
    // ------------------------------------------------------------
    localparam int k_w = 18;
    // 65536 + 20091
    localparam logic signed [k_w-1:0] k_cos = 18'sd85627;
    localparam logic signed [k_w-1:0] k_sin = 18'sd35468;

    // ------------------------------------------------------------
    // APB register map
    // ------------------------------------------------------------
    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;

    localparam logic [apb_addr_w-1:0] addr_ctrl   = 8'h00;
    localparam logic [apb_addr_w-1:0] addr_status = 8'h04;
    localparam logic [apb_addr_w-1:0] addr_quant  = 8'h08;
    // Eight words, two coefficients each
    localparam logic [apb_addr_w-1:0] addr_coef0  = 8'h10;
    // Four words, four pixels each
    localparam logic [apb_addr_w-1:0] addr_pred0  = 8'h30;
    localparam logic [apb_addr_w-1:0] addr_recon0 = 8'h40;

    // One bus word seen as coefficient pair or pixel quad
    typedef union packed {
        logic [1:0][coef_w-1:0] coef;
        logic [3:0][pix_w-1:0]  pix;
    } apb_word_u;

endpackage

`default_nettype wire

/* vp8_apb_regs.sv */
// VP8 reconstruction APB register file
`timescale 1ns/1ps
`default_nettype none

module vp8_apb_regs (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 psel_i,
    input  logic                                                 penable_i,
    input  logic                                                 pwrite_i,
    input  logic [vp8_recon_pkg::apb_addr_w-1:0]                 paddr_i,
    input  logic [vp8_recon_pkg::apb_data_w-1:0]                 pwdata_i,
    input  logic [vp8_recon_pkg::blk_n*vp8_recon_pkg::pix_w-1:0] recon_i,
    input  logic                                                 recon_valid_i,
    output logic [vp8_recon_pkg::apb_data_w-1:0]                 prdata_o,
    output logic                                                 pready_o,
    output logic [vp8_recon_pkg::blk_n*vp8_recon_pkg::coef_w-1:0] coef_o,
    output logic [vp8_recon_pkg::blk_n*vp8_recon_pkg::pix_w-1:0] pred_o,
    output logic [vp8_recon_pkg::quant_w-1:0]                    dc_q_o,
    output logic [vp8_recon_pkg::quant_w-1:0]                    ac_q_o,
    output logic                                                 start_o
);

    // Storage, one outer element per bus word
    logic [vp8_recon_pkg::blk_n/2-1:0][1:0][vp8_recon_pkg::coef_w-1:0] coef_q;
    logic [vp8_recon_pkg::blk_n/4-1:0][3:0][vp8_recon_pkg::pix_w-1:0]  pred_q;
    logic [vp8_recon_pkg::blk_n/4-1:0][3:0][vp8_recon_pkg::pix_w-1:0]  recon_q;
    logic [vp8_recon_pkg::quant_w-1:0] dc_q;
    logic [vp8_recon_pkg::quant_w-1:0] ac_q;
    logic                              start_q;
    logic                              done_q;

    vp8_recon_pkg::apb_word_u wdata_u;
    vp8_recon_pkg::apb_word_u rdata_u;

    logic                                  wr_en;
    logic                                  aligned;
    logic                                  coef_hit;
    logic                                  pred_hit;
    logic                                  recon_hit;
    logic [vp8_recon_pkg::apb_addr_w-1:0]  coef_off;
    logic [vp8_recon_pkg::apb_addr_w-1:0]  pred_off;
    logic [vp8_recon_pkg::apb_addr_w-1:0]  recon_off;
    logic [2:0]                            coef_idx;
    logic [1:0]                            pred_idx;
    logic [1:0]                            recon_idx;

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------
    assign wr_en   = psel_i & penable_i & pwrite_i;
    assign aligned = (paddr_i[1:0] == 2'b00);
    assign wdata_u = pwdata_i;

    assign coef_hit  = aligned && (paddr_i >= vp8_recon_pkg::addr_coef0)
                               && (paddr_i <  vp8_recon_pkg::addr_pred0);
    assign pred_hit  = aligned && (paddr_i >= vp8_recon_pkg::addr_pred0)
                               && (paddr_i <  vp8_recon_pkg::addr_recon0);
    assign recon_hit = aligned && (paddr_i >= vp8_recon_pkg::addr_recon0)
                               && (paddr_i <  vp8_recon_pkg::addr_recon0 + 8'h10);

    assign coef_off  = paddr_i - vp8_recon_pkg::addr_coef0;
    assign pred_off  = paddr_i - vp8_recon_pkg::addr_pred0;
    assign recon_off = paddr_i - vp8_recon_pkg::addr_recon0;
    assign coef_idx  = coef_off[4:2];
    assign pred_idx  = pred_off[3:2];
    assign recon_idx = recon_off[3:2];

    // ------------------------------------------------------------
    // Register writes, start pulse and done flag
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            coef_q  <= '0;
            pred_q  <= '0;
            recon_q <= '0;
            dc_q    <= '0;
            ac_q    <= '0;
            start_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            start_q <= wr_en && (paddr_i == vp8_recon_pkg::addr_ctrl) && pwdata_i[0];
            if (wr_en && coef_hit) begin
                coef_q[coef_idx] <= wdata_u.coef;
            end
            if (wr_en && pred_hit) begin
                pred_q[pred_idx] <= wdata_u.pix;
            end
            if (wr_en && (paddr_i == vp8_recon_pkg::addr_quant)) begin
                dc_q <= pwdata_i[vp8_recon_pkg::quant_w-1:0];
                ac_q <= pwdata_i[16 +: vp8_recon_pkg::quant_w];
            end
            if (recon_valid_i) begin
                recon_q <= recon_i;
            end
            // A fresh start wins over a result still draining
            if (start_q) begin
                done_q <= 1'b0;
            end else if (recon_valid_i) begin
                done_q <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Read mux, CTRL and unmapped space read as zero
    // ------------------------------------------------------------
    always_comb begin
        rdata_u = '0;
        if (coef_hit) begin
            rdata_u.coef = coef_q[coef_idx];
        end else if (pred_hit) begin
            rdata_u.pix = pred_q[pred_idx];
        end else if (recon_hit) begin
            rdata_u.pix = recon_q[recon_idx];
        end else if (paddr_i == vp8_recon_pkg::addr_status) begin
            rdata_u = {31'b0, done_q};
        end else if (paddr_i == vp8_recon_pkg::addr_quant) begin
            rdata_u = {{(16-vp8_recon_pkg::quant_w){1'b0}}, ac_q,
                       {(16-vp8_recon_pkg::quant_w){1'b0}}, dc_q};
        end
    end

    assign prdata_o = rdata_u;
    assign pready_o = 1'b1;
    assign coef_o   = coef_q;
    assign pred_o   = pred_q;
    assign dc_q_o   = dc_q;
    assign ac_q_o   = ac_q;
    assign start_o  = start_q;

endmodule

`default_nettype wire

/* vp8_dequant.sv */
// VP8 coefficient dequantizer
`timescale 1ns/1ps
`default_nettype none

module vp8_dequant (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic [vp8_recon_pkg::blk_n*vp8_recon_pkg::coef_w-1:0] coef_i,
    input  logic [vp8_recon_pkg::quant_w-1:0]                     dc_q_i,
    input  logic [vp8_recon_pkg::quant_w-1:0]                     ac_q_i,
    input  logic                                                  start_i,
    output logic [vp8_recon_pkg::blk_n*vp8_recon_pkg::coef_w-1:0] dq_coef_o,
    output logic                                                  dq_valid_o
);

    logic [vp8_recon_pkg::blk_n-1:0][vp8_recon_pkg::coef_w-1:0] coef_a;
    logic [vp8_recon_pkg::blk_n-1:0][vp8_recon_pkg::coef_w-1:0] dq_d;
    logic [vp8_recon_pkg::blk_n-1:0][vp8_recon_pkg::coef_w-1:0] dq_q;
    logic                                                       valid_q;

    // Clip a product to the signed coefficient range
    function automatic logic [vp8_recon_pkg::coef_w-1:0] sat_coef(
        input logic signed [vp8_recon_pkg::prod_w-1:0] prod
    );
        logic [vp8_recon_pkg::prod_w-vp8_recon_pkg::coef_w:0] top;
        top = prod[vp8_recon_pkg::prod_w-1:vp8_recon_pkg::coef_w-1];
        if ((top == '0) || (top == '1)) begin
            return prod[vp8_recon_pkg::coef_w-1:0];
        end else if (prod[vp8_recon_pkg::prod_w-1]) begin
            return {1'b1, {(vp8_recon_pkg::coef_w-1){1'b0}}};
        end
        return {1'b0, {(vp8_recon_pkg::coef_w-1){1'b1}}};
    endfunction

    assign coef_a = coef_i;

    // DC factor for index 0, AC factor for the rest
    always_comb begin
        for (int k = 0; k < vp8_recon_pkg::blk_n; k++) begin
            dq_d[k] = sat_coef($signed(coef_a[k]) *
                               $signed({1'b0, (k == 0) ? dc_q_i : ac_q_i}));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dq_q    <= '0;
            valid_q <= 1'b0;
        end else begin
            dq_q    <= dq_d;
            valid_q <= start_i;
        end
    end

    assign dq_coef_o  = dq_q;
    assign dq_valid_o = valid_q;

endmodule

`default_nettype wire

/* vp8_idct4x4.sv */
// VP8 4x4 inverse transform with reconstruction
`timescale 1ns/1ps
`default_nettype none

module vp8_idct4x4 (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic [vp8_recon_pkg::blk_n*vp8_recon_pkg::coef_w-1:0] coef_i,
    input  logic [vp8_recon_pkg::blk_n*vp8_recon_pkg::pix_w-1:0]  pred_i,
    input  logic                                                  valid_i,
    output logic [vp8_recon_pkg::blk_n*vp8_recon_pkg::pix_w-1:0]  recon_o,
    output logic                                                  recon_valid_o
);

    logic [vp8_recon_pkg::blk_n-1:0][vp8_recon_pkg::coef_w-1:0] coef_a;
    logic [vp8_recon_pkg::blk_n-1:0][vp8_recon_pkg::tmp_w-1:0]  tmp_d;
    logic [vp8_recon_pkg::blk_n-1:0][vp8_recon_pkg::tmp_w-1:0]  tmp_q;
    logic [vp8_recon_pkg::blk_n-1:0][vp8_recon_pkg::pix_w-1:0]  pred_s1;
    logic [vp8_recon_pkg::blk_n-1:0][vp8_recon_pkg::pix_w-1:0]  recon_d;
    logic [vp8_recon_pkg::blk_n-1:0][vp8_recon_pkg::pix_w-1:0]  recon_q;
    logic                                                       valid_s1;
    logic                                                       valid_s2;

    // Fixed-point multiply, arithmetic shift by 16
    function automatic logic signed [vp8_recon_pkg::tmp_w-1:0] mul_k(
        input logic signed [vp8_recon_pkg::tmp_w-1:0] x,
        input logic signed [vp8_recon_pkg::k_w-1:0]   k
    );
        logic signed [vp8_recon_pkg::tmp_w+vp8_recon_pkg::k_w-1:0] p;
        p = x * k;
        p = p >>> 16;
        return p[vp8_recon_pkg::tmp_w-1:0];
    endfunction

    // Negative to 0, anything above 8 bits to 255
    function automatic logic [vp8_recon_pkg::pix_w-1:0] clamp_pix(
        input logic signed [vp8_recon_pkg::sum_w-1:0] v
    );
        if (v[vp8_recon_pkg::sum_w-1]) begin
            return '0;
        end else if (v[vp8_recon_pkg::sum_w-2:vp8_recon_pkg::pix_w] != '0) begin
            return '1;
        end
        return v[vp8_recon_pkg::pix_w-1:0];
    endfunction

    assign coef_a = coef_i;

    // ------------------------------------------------------------
    // Pass one, vertical butterflies
    // ------------------------------------------------------------
    always_comb begin
        logic signed [vp8_recon_pkg::tmp_w-1:0] x0, x4, x8, x12;
        logic signed [vp8_recon_pkg::tmp_w-1:0] a0, a1, a2, a3;
        for (int i = 0; i < 4; i++) begin
            x0  = $signed(coef_a[i]);
            x4  = $signed(coef_a[i+4]);
            x8  = $signed(coef_a[i+8]);
            x12 = $signed(coef_a[i+12]);
            a0  = x0 + x8;
            a1  = x0 - x8;
            a2  = mul_k(x4, vp8_recon_pkg::k_sin) - mul_k(x12, vp8_recon_pkg::k_cos);
            a3  = mul_k(x4, vp8_recon_pkg::k_cos) + mul_k(x12, vp8_recon_pkg::k_sin);
            tmp_d[4*i+0] = a0 + a3;
            tmp_d[4*i+1] = a1 + a2;
            tmp_d[4*i+2] = a1 - a2;
            tmp_d[4*i+3] = a0 - a3;
        end
    end

    // ------------------------------------------------------------
    // Pass two, rounding, predictor add and clamp
    // ------------------------------------------------------------
    always_comb begin
        logic signed [vp8_recon_pkg::sum_w-1:0] b0, b1, b2, b3;
        logic signed [vp8_recon_pkg::sum_w-1:0] s0, s1, s2, s3;
        for (int i = 0; i < 4; i++) begin
            b0 = $signed(tmp_q[i]) + $signed(tmp_q[i+8]) + 4;
            b1 = $signed(tmp_q[i]) - $signed(tmp_q[i+8]) + 4;
            b2 = mul_k(tmp_q[i+4], vp8_recon_pkg::k_sin)
               - mul_k(tmp_q[i+12], vp8_recon_pkg::k_cos);
            b3 = mul_k(tmp_q[i+4], vp8_recon_pkg::k_cos)
               + mul_k(tmp_q[i+12], vp8_recon_pkg::k_sin);
            s0 = ((b0 + b3) >>> 3) + $signed({1'b0, pred_s1[4*i+0]});
            s1 = ((b1 + b2) >>> 3) + $signed({1'b0, pred_s1[4*i+1]});
            s2 = ((b1 - b2) >>> 3) + $signed({1'b0, pred_s1[4*i+2]});
            s3 = ((b0 - b3) >>> 3) + $signed({1'b0, pred_s1[4*i+3]});
            recon_d[4*i+0] = clamp_pix(s0);
            recon_d[4*i+1] = clamp_pix(s1);
            recon_d[4*i+2] = clamp_pix(s2);
            recon_d[4*i+3] = clamp_pix(s3);
        end
    end

    // Predictor rides along with pass one so it stays with its block
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmp_q    <= '0;
            pred_s1  <= '0;
            recon_q  <= '0;
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else begin
            tmp_q    <= tmp_d;
            pred_s1  <= pred_i;
            recon_q  <= recon_d;
            valid_s1 <= valid_i;
            valid_s2 <= valid_s1;
        end
    end

    assign recon_o       = recon_q;
    assign recon_valid_o = valid_s2;

endmodule

`default_nettype wire

/* vp8_recon_top.sv */
// VP8 luma block reconstruction top
`timescale 1ns/1ps
`default_nettype none

module vp8_recon_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  psel_i,
    input  logic                                  penable_i,
    input  logic                                  pwrite_i,
    input  logic [vp8_recon_pkg::apb_addr_w-1:0]  paddr_i,
    input  logic [vp8_recon_pkg::apb_data_w-1:0]  pwdata_i,
    output logic [vp8_recon_pkg::apb_data_w-1:0]  prdata_o,
    output logic                                  pready_o
);

    logic [vp8_recon_pkg::blk_n*vp8_recon_pkg::coef_w-1:0] coef;
    logic [vp8_recon_pkg::blk_n*vp8_recon_pkg::pix_w-1:0]  pred;
    logic [vp8_recon_pkg::quant_w-1:0]                     dc_q;
    logic [vp8_recon_pkg::quant_w-1:0]                     ac_q;
    logic                                                  start;
    logic [vp8_recon_pkg::blk_n*vp8_recon_pkg::coef_w-1:0] dq_coef;
    logic                                                  dq_valid;
    logic [vp8_recon_pkg::blk_n*vp8_recon_pkg::pix_w-1:0]  recon;
    logic                                                  recon_valid;

    vp8_apb_regs u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .recon_i       (recon),
        .recon_valid_i (recon_valid),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .coef_o        (coef),
        .pred_o        (pred),
        .dc_q_o        (dc_q),
        .ac_q_o        (ac_q),
        .start_o       (start)
    );

    // One cycle dequant, then two cycle transform
    vp8_dequant u_dequant (
        .clk        (clk),
        .rst_n      (rst_n),
        .coef_i     (coef),
        .dc_q_i     (dc_q),
        .ac_q_i     (ac_q),
        .start_i    (start),
        .dq_coef_o  (dq_coef),
        .dq_valid_o (dq_valid)
    );

    vp8_idct4x4 u_idct (
        .clk           (clk),
        .rst_n         (rst_n),
        .coef_i        (dq_coef),
        .pred_i        (pred),
        .valid_i       (dq_valid),
        .recon_o       (recon),
        .recon_valid_o (recon_valid)
    );

endmodule

`default_nettype wire

/* tb_vp8_checker.sv */
// VP8 reconstruction checker
`timescale 1ns/1ps
`default_nettype none

module tb_vp8_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [7:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    input  logic [31:0] prdata_i,
    output int          error_count_o
);

    // Transform multipliers in 16-bit fixed point
    localparam longint mul_cos = 85627;
    localparam longint mul_sin = 35468;

    int          coef_sh [16];
    int          pred_sh [16];
    int          dc_sh;
    int          ac_sh;
    logic [31:0] recon_exp [4];
    logic        fresh_start;
    logic        done_seen;
    int          errors = 0;

    vp8_recon_pkg::apb_word_u word_u;

    assign error_count_o = errors;

    function automatic longint fixmul(input longint x, input longint k);
        return (x * k) >>> 16;
    endfunction

    // ------------------------------------------------------------
    // Reference model of one block
    // ------------------------------------------------------------
    task automatic predict_block();
        longint dq [16];
        longint tmp [16];
        longint out [4];
        longint a0, a1, a2, a3, v;
        for (int k = 0; k < 16; k++) begin
            dq[k] = longint'(coef_sh[k]) * ((k == 0) ? dc_sh : ac_sh);
            if (dq[k] > 32767) begin
                dq[k] = 32767;
            end else if (dq[k] < -32768) begin
                dq[k] = -32768;
            end
        end
        // Columns
        for (int i = 0; i < 4; i++) begin
            a0 = dq[i] + dq[i+8];
            a1 = dq[i] - dq[i+8];
            a2 = fixmul(dq[i+4], mul_sin) - fixmul(dq[i+12], mul_cos);
            a3 = fixmul(dq[i+4], mul_cos) + fixmul(dq[i+12], mul_sin);
            tmp[4*i+0] = a0 + a3;
            tmp[4*i+1] = a1 + a2;
            tmp[4*i+2] = a1 - a2;
            tmp[4*i+3] = a0 - a3;
        end
        // Second pass with rounding, predictor and clamp
        for (int i = 0; i < 4; i++) begin
            a0 = tmp[i] + tmp[i+8] + 4;
            a1 = tmp[i] - tmp[i+8] + 4;
            a2 = fixmul(tmp[i+4], mul_sin) - fixmul(tmp[i+12], mul_cos);
            a3 = fixmul(tmp[i+4], mul_cos) + fixmul(tmp[i+12], mul_sin);
            out[0] = (a0 + a3) >>> 3;
            out[1] = (a1 + a2) >>> 3;
            out[2] = (a1 - a2) >>> 3;
            out[3] = (a0 - a3) >>> 3;
            for (int j = 0; j < 4; j++) begin
                v = out[j] + pred_sh[4*i+j];
                if (v < 0) begin
                    v = 0;
                end else if (v > 255) begin
                    v = 255;
                end
                recon_exp[i][8*j +: 8] = v[7:0];
            end
        end
    endtask

    task automatic take_write();
        int w;
        w = int'(paddr_i) >> 2;
        word_u = pwdata_i;
        if (paddr_i[1:0] == 2'b00 && w >= 4 && w < 12) begin
            coef_sh[2*(w-4)]   = int'($signed(word_u.coef[0]));
            coef_sh[2*(w-4)+1] = int'($signed(word_u.coef[1]));
        end else if (paddr_i[1:0] == 2'b00 && w >= 12 && w < 16) begin
            for (int b = 0; b < 4; b++) begin
                pred_sh[4*(w-12)+b] = int'(word_u.pix[b]);
            end
        end else if (paddr_i == 8'h08) begin
            dc_sh = int'(pwdata_i[8:0]);
            ac_sh = int'(pwdata_i[24:16]);
        end else if (paddr_i == 8'h00 && pwdata_i[0]) begin
            predict_block();
            fresh_start = 1'b1;
            done_seen   = 1'b0;
        end
    endtask

    task automatic check_read();
        logic [31:0] exp;
        logic [31:0] care;
        int          w;
        w    = int'(paddr_i) >> 2;
        exp  = '0;
        care = '1;
        if (paddr_i[1:0] == 2'b00) begin
            if (w >= 4 && w < 12) begin
                exp = {16'(coef_sh[2*(w-4)+1]), 16'(coef_sh[2*(w-4)])};
            end else if (w >= 12 && w < 16) begin
                for (int b = 0; b < 4; b++) begin
                    exp[8*b +: 8] = 8'(pred_sh[4*(w-12)+b]);
                end
            end else if (w >= 16 && w < 20) begin
                exp = recon_exp[w-16];
            end else if (w == 2) begin
                exp = {7'b0, 9'(ac_sh), 7'b0, 9'(dc_sh)};
            end else if (w == 1) begin
                // Done is low right after a start and sticky once seen high
                if (done_seen) begin
                    exp = 32'h1;
                end else if (!fresh_start) begin
                    care = 32'hffff_fffe;
                end
                fresh_start = 1'b0;
                if (prdata_i[0]) begin
                    done_seen = 1'b1;
                end
            end
        end
        if ((prdata_i & care) != (exp & care)) begin
            errors++;
            $display("mismatch at %0t: prdata_o at 0x%02h expected %08h got %08h",
                     $time, paddr_i, exp & care, prdata_i & care);
        end
    endtask

    // Snoop completed transfers
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < 16; k++) begin
                coef_sh[k] = 0;
                pred_sh[k] = 0;
            end
            for (int i = 0; i < 4; i++) begin
                recon_exp[i] = '0;
            end
            dc_sh       = 0;
            ac_sh       = 0;
            fresh_start = 1'b1;
            done_seen   = 1'b0;
        end else if (psel_i && penable_i) begin
            if (pwrite_i) begin
                take_write();
            end else begin
                check_read();
            end
        end
    end

endmodule

`default_nettype wire

/* tb_vp8_recon.sv */
// VP8 reconstruction testbench
`timescale 1ns/1ps
`default_nettype none

module tb_vp8_recon;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic [31:0] rd;
    int          seed;
    int          timeouts;
    int          errors;

    vp8_recon_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready)
    );

    tb_vp8_checker checker0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .psel_i        (psel),
        .penable_i     (penable),
        .pwrite_i      (pwrite),
        .paddr_i       (paddr),
        .pwdata_i      (pwdata),
        .prdata_i      (prdata),
        .error_count_o (errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Last resort if some wait loop misbehaves
    initial begin
        #5000000;
        $display("Run stopped by the watchdog before the test sequence ended");
        $display("Something failed");
        $finish;
    end

    // ------------------------------------------------------------
    // APB transfers with inputs changing on the falling edge
    // ------------------------------------------------------------
    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata);
        int n;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        n = 0;
        while (!pready && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!pready) begin
            timeouts++;
            $display("Timeout at %0t: pready stayed low at address 0x%02h", $time, addr);
        end
        @(negedge clk);
        rdata   = prdata;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        apb_access(1'b0, addr, 32'h0, data);
    endtask

    // 0 random, 1 zero, 2 full scale, 3 DC only at full scale
    function automatic logic [15:0] pick_coef(input int mode, input int k);
        int r;
        r = $random(seed);
        case (mode)
            0: return 16'((r & 32'hfff) - 2048);
            1: return 16'h0000;
            2: return r[0] ? 16'h7fff : 16'h8000;
            default: return (k == 0) ? (r[0] ? 16'h7fff : 16'h8000) : 16'h0000;
        endcase
    endfunction

    task automatic run_block(input int mode);
        logic [15:0] c [16];
        logic [8:0]  dc;
        logic [8:0]  ac;
        logic [31:0] st;
        int          n;
        for (int k = 0; k < 16; k++) begin
            c[k] = pick_coef(mode, k);
        end
        for (int i = 0; i < 8; i++) begin
            write_reg(8'h10 + 8'(4*i), {c[2*i+1], c[2*i]});
        end
        if (mode >= 2) begin
            dc = 9'(256 + {$random(seed)} % 256);
            ac = 9'(256 + {$random(seed)} % 256);
        end else begin
            dc = 9'(4 + {$random(seed)} % 281);
            ac = 9'(4 + {$random(seed)} % 281);
        end
        write_reg(8'h08, {7'b0, ac, 7'b0, dc});
        for (int i = 0; i < 4; i++) begin
            write_reg(8'h30 + 8'(4*i), $random(seed));
        end
        write_reg(8'h00, 32'h1);
        // First poll also shows that start cleared done
        st = '0;
        n  = 0;
        while (!st[0] && n < 20) begin
            read_reg(8'h04, st);
            n++;
        end
        if (!st[0]) begin
            timeouts++;
            $display("Timeout at %0t: done never came back after start", $time);
        end
        for (int i = 0; i < 4; i++) begin
            read_reg(8'h40 + 8'(4*i), rd);
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        seed     = 32'h1c3e;
        timeouts = 0;
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        read_reg(8'h04, rd);
        for (int i = 0; i < 4; i++) begin
            read_reg(8'h40 + 8'(4*i), rd);
        end

        for (int b = 0; b < 200; b++) begin
            run_block(0);
        end
        for (int b = 0; b < 8; b++) begin
            run_block(1);
        end
        for (int b = 0; b < 16; b++) begin
            run_block(2 + b % 2);
        end

        // Read-only and unmapped space
        write_reg(8'h04, 32'hffff_fffe);
        write_reg(8'h44, 32'h1234_5678);
        write_reg(8'h50, 32'hdead_beef);
        write_reg(8'h12, 32'h0bad_cafe);
        read_reg(8'h04, rd);
        read_reg(8'h44, rd);
        read_reg(8'h50, rd);
        read_reg(8'h12, rd);
        read_reg(8'h0c, rd);
        read_reg(8'hfc, rd);
        read_reg(8'h00, rd);

        // Factors, coefficients and predictor read back
        for (int a = 8'h08; a < 8'h40; a += 4) begin
            read_reg(8'(a), rd);
        end

        repeat (4) @(negedge clk);
        $display("Checks done: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
vp8_recon_pkg.sv
vp8_apb_regs.sv
vp8_dequant.sv
vp8_idct4x4.sv
vp8_recon_top.sv
tb_vp8_checker.sv
tb_vp8_recon.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_vp8_recon \
    -o sim_vp8 > build.log 2>&1 &&
./obj_dir/sim_vp8 | tee sim.log &&
grep -q "Everything OK" sim.log && echo "PASS" ||
{ echo "FAIL, see build.log and sim.log"; exit 1; }
